//--- cache_system.f
cpu_types_pkg.sv
dcache.sv
ram.sv
cache_system.sv
tb_clock_gen.sv
cache_system_assertions.sv
cache_system_tb.sv

//--- Makefile
TOP := cache_system_tb

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f cache_system.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f cache_system.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

//--- cache_system_tb.sv
module cache_system_tb import cpu_types_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RAM_ADDR_W = 8;
	localparam int MEM_LAT    = 2;
	localparam int RAM_WORDS  = 1 << RAM_ADDR_W;
	localparam int NUM_RAND   = 400;
	localparam int NUM_DIRECT = 8;
	// writeback and fetch of two words each, fill, drive and gap cycles
	localparam int MISS_COST  = 4 * (MEM_LAT + 1) + 3;
	localparam int FLUSH_COST = DWAYS * DSETS * (2 * (MEM_LAT + 1) + 1);
	// random reads may be repeated, so up to two accesses per draw
	localparam int MAX_CYCLES = (2 * NUM_RAND + 2 * NUM_DIRECT) * MISS_COST + FLUSH_COST + 200;

	logic  CLK, nRST;
	logic  dmemREN, dmemWEN, halt;
	word_t dmemaddr, dmemstore, dmemload;
	logic  dhit, flushed;
	logic  dREN, dWEN;
	word_t daddr, dstore;

	// expected memory, and what the bus actually wrote
	word_t       model  [RAM_WORDS];
	word_t       shadow [RAM_WORDS];
	logic [15:0] lfsr;
	int read_errors, bus_errors, flush_errors, timing_errors;
	int cycle_cnt = 0;

	tb_clock_gen clock_gen_i (
		.CLK  (CLK),
		.nRST (nRST)
	);

	cache_system #(
		.RAM_ADDR_W (RAM_ADDR_W),
		.MEM_LAT    (MEM_LAT)
	) cache_system_i (
		.CLK (CLK), .nRST (nRST),
		.dmemREN (dmemREN), .dmemWEN (dmemWEN), .halt (halt),
		.dmemaddr (dmemaddr), .dmemstore (dmemstore),
		.dhit (dhit), .flushed (flushed), .dmemload (dmemload),
		.dREN (dREN), .dWEN (dWEN), .daddr (daddr), .dstore (dstore)
	);

	bind dcache cache_system_assertions assertions_i (
		.CLK (CLK), .nRST (nRST), .dmemREN (dmemREN), .dmemWEN (dmemWEN),
		.dmemaddr (dmemaddr), .dhit (dhit), .flushed (flushed),
		.dREN (dREN), .dWEN (dWEN)
	);

	// galois lfsr, taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hb400;
		end
		return n;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	// tag, set, block word, byte offset
	function automatic word_t make_addr(input logic [2:0] tag, input logic [2:0] idx,
			input logic blk);
		return {23'd0, tag, idx, blk, 2'b00};
	endfunction

	function automatic int word_index(input word_t a);
		return int'(a[RAM_ADDR_W+DBYT_W-1:DBYT_W]);
	endfunction

	// one request held until dhit, then dropped for a cycle
	task automatic run_access(input logic wr, input word_t addr, input word_t data,
			output int waits);
		int widx;
		widx  = word_index(addr);
		waits = 0;
		@(posedge CLK);
		dmemREN   <= !wr;
		dmemWEN   <= wr;
		dmemaddr  <= addr;
		dmemstore <= data;
		@(negedge CLK);
		while (!dhit) begin
			waits++;
			@(negedge CLK);
		end
		if (wr) begin
			model[widx] = data;
		end else if (dmemload !== model[widx]) begin
			read_errors++;
			$display("[ERROR] dmemload addr=%h expected=%h got=%h", addr, model[widx], dmemload);
		end
		@(posedge CLK);
		dmemREN <= 1'b0;
		dmemWEN <= 1'b0;
	endtask

	// bus writes must carry the latest value of their word
	always @(negedge CLK) begin
		int bidx;
		if (nRST && dWEN && !cache_system_i.dwait) begin
			bidx = word_index(daddr);
			if (dstore !== model[bidx]) begin
				bus_errors++;
				$display("[ERROR] dstore daddr=%h expected=%h got=%h", daddr, model[bidx], dstore);
			end
			shadow[bidx] = dstore;
		end
	end

	always @(posedge CLK) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial begin
		int          waits;
		int          total;
		logic [31:0] r;
		logic        wr;
		logic [2:0]  tag;
		logic [2:0]  idx;
		logic        blk;
		word_t       addr;
		word_t       data;

		lfsr          = 16'd49732;
		read_errors   = 0;
		bus_errors    = 0;
		flush_errors  = 0;
		timing_errors = 0;
		dmemREN       = 1'b0;
		dmemWEN       = 1'b0;
		halt          = 1'b0;
		dmemaddr      = '0;
		dmemstore     = '0;
		for (int i = 0; i < RAM_WORDS; i++) begin
			model[i]  = init_word(word_t'(i));
			shadow[i] = init_word(word_t'(i));
		end

		@(posedge nRST);
		@(negedge CLK);
		if (dhit || dREN || dWEN || flushed) begin
			timing_errors++;
			$display("cache outputs were active right after reset");
		end

		// eight tags into set 1 force dirty evictions and write-miss merges
		for (int k = 0; k < NUM_DIRECT; k++) begin
			take_bits(32, r);
			run_access(1'b1, make_addr(k[2:0], 3'd1, k[0]), r, waits);
		end
		for (int k = 0; k < NUM_DIRECT; k++) begin
			run_access(1'b0, make_addr(k[2:0], 3'd1, k[0]), '0, waits);
		end

		// 64 words: 8 tags, sets 0..3, two words per block
		for (int n = 0; n < NUM_RAND; n++) begin
			take_bits(3, r);
			wr = (r[2:0] < 3'd3);
			take_bits(3, r);
			tag = r[2:0];
			take_bits(2, r);
			idx = {1'b0, r[1:0]};
			take_bits(1, r);
			blk  = r[0];
			addr = make_addr(tag, idx, blk);
			data = '0;
			if (wr) begin
				take_bits(32, data);
			end
			run_access(wr, addr, data, waits);
			if (!wr) begin
				take_bits(2, r);
				if (r[1:0] == 2'd0) begin
					run_access(1'b0, addr, '0, waits);
					if (waits != 0) begin
						timing_errors++;
						$display("repeated read of %h did not hit in its strobe cycle", addr);
					end
				end
			end
		end

		// flush walk
		@(posedge CLK);
		halt <= 1'b1;
		@(negedge CLK);
		while (!flushed) begin
			@(negedge CLK);
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			if (shadow[i] !== model[i]) begin
				flush_errors++;
				$display("[ERROR] dstore daddr=%h expected=%h written=%h",
					word_t'(i << DBYT_W), model[i], shadow[i]);
			end
		end

		total = read_errors + bus_errors + flush_errors + timing_errors;
		$display("errors: read %0d, bus %0d, flush %0d, timing %0d, total %0d",
			read_errors, bus_errors, flush_errors, timing_errors, total);
		if (total == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- cache_system_assertions.sv
module cache_system_assertions import cpu_types_pkg::*; (
	input logic  CLK,
	input logic  nRST,
	input logic  dmemREN,
	input logic  dmemWEN,
	input word_t dmemaddr,
	input logic  dhit,
	input logic  flushed,
	input logic  dREN,
	input logic  dWEN
);
	timeunit 1ns;
	timeprecision 100ps;

	// memory bus carries one direction at a time
	bus_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
		else $error("dREN and dWEN high together");

	// one completion per request, even if the requester holds it
	hit_single: assert property (@(posedge CLK) disable iff (!nRST)
		dhit |=> !(dhit && $stable(dmemaddr) && $stable(dmemREN) && $stable(dmemWEN)))
		else $error("dhit high two cycles in a row for one request");

	// flushed holds until reset
	flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
		else $error("flushed dropped before reset");

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
	output logic CLK,
	output logic nRST
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 5;

	// 10 ns period
	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		nRST <= 1'b1;
	end

endmodule

//--- cache_system.sv
module cache_system import cpu_types_pkg::*; #(
	parameter int RAM_ADDR_W = 8,
	parameter int MEM_LAT    = 2
) (
	input  logic  CLK,
	input  logic  nRST,
	// datapath side
	input  logic  dmemREN,
	input  logic  dmemWEN,
	input  logic  halt,
	input  word_t dmemaddr,
	input  word_t dmemstore,
	output logic  dhit,
	output logic  flushed,
	output word_t dmemload,
	// memory bus monitor
	output logic  dREN,
	output logic  dWEN,
	output word_t daddr,
	output word_t dstore
);

	word_t dload;
	logic  dwait;

	dcache dcache_i (
		.CLK       (CLK),
		.nRST      (nRST),
		.dmemREN   (dmemREN),
		.dmemWEN   (dmemWEN),
		.halt      (halt),
		.dmemaddr  (dmemaddr),
		.dmemstore (dmemstore),
		.dhit      (dhit),
		.flushed   (flushed),
		.dmemload  (dmemload),
		.dload     (dload),
		.dwait     (dwait),
		.dREN      (dREN),
		.dWEN      (dWEN),
		.daddr     (daddr),
		.dstore    (dstore)
	);

	ram #(
		.RAM_ADDR_W (RAM_ADDR_W),
		.MEM_LAT    (MEM_LAT)
	) ram_i (
		.CLK    (CLK),
		.nRST   (nRST),
		.dREN   (dREN),
		.dWEN   (dWEN),
		.daddr  (daddr),
		.dstore (dstore),
		.dload  (dload),
		.dwait  (dwait)
	);

endmodule

//--- ram.sv
module ram import cpu_types_pkg::*; #(
	parameter int RAM_ADDR_W = 8,
	parameter int MEM_LAT    = 2
) (
	input  logic  CLK,
	input  logic  nRST,
	input  logic  dREN,
	input  logic  dWEN,
	input  word_t daddr,
	input  word_t dstore,
	output word_t dload,
	output logic  dwait
);

	localparam int DEPTH = 1 << RAM_ADDR_W;
	// counter must reach MEM_LAT
	localparam int CNT_W = (MEM_LAT > 1) ? $clog2(MEM_LAT + 1) : 1;

	word_t mem [DEPTH];

	logic [RAM_ADDR_W-1:0] widx;
	logic [CNT_W-1:0]      lat_cnt;
	logic                  req;
	logic                  done;

	// word index sits just above the byte offset
	assign widx = daddr[RAM_ADDR_W+DBYT_W-1:DBYT_W];

	assign req = dREN || dWEN;

	// a word completes after MEM_LAT busy cycles
	assign done  = req && (lat_cnt == CNT_W'(MEM_LAT));
	assign dwait = !done;

	// restart on idle and after each completed word
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lat_cnt <= '0;
		end else if (!req || done) begin
			lat_cnt <= '0;
		end else begin
			lat_cnt <= lat_cnt + 1'b1;
		end
	end

	// contents come back to the known pattern on every reset
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= init_word(word_t'(i));
			end
		end else if (done && dWEN) begin
			mem[widx] <= dstore;
		end
	end

	// read data valid in the completing cycle
	assign dload = mem[widx];

endmodule

//--- dcache.sv
module dcache import cpu_types_pkg::*; (
	input  logic  CLK,
	input  logic  nRST,
	// datapath side
	input  logic  dmemREN,
	input  logic  dmemWEN,
	input  logic  halt,
	input  word_t dmemaddr,
	input  word_t dmemstore,
	output logic  dhit,
	output logic  flushed,
	output word_t dmemload,
	// memory side
	input  word_t dload,
	input  logic  dwait,
	output logic  dREN,
	output logic  dWEN,
	output word_t daddr,
	output word_t dstore
);

	typedef enum logic [3:0] {
		IDLE,
		WB0,
		WB1,
		FETCH0,
		FETCH1,
		FILL,
		FLUSH0,
		FLUSH1,
		FLUSHED
	} state_t;

	state_t state, next_state;

	// storage, indexed [way][set]
	logic [DTAG_W-1:0] tag_q   [DWAYS][DSETS];
	word_t             data_q  [DWAYS][DSETS][DWORDS];
	logic              valid_q [DWAYS][DSETS];
	logic              dirty_q [DWAYS][DSETS];
	// way touched last, one bit per set
	logic [DSETS-1:0]  mru_q;

	dcachef_t          req_addr;
	logic [DTAG_W-1:0] req_tag;
	logic [DIDX_W-1:0] req_idx;
	logic [DBLK_W-1:0] req_off;

	logic req;
	logic hit0, hit1, hit;
	logic hit_way;
	logic idle_hit;
	logic victim_sel, victim_q;
	logic victim_dirty;
	logic rd_way;
	logic mem_done;

	// flush walk position: way in the top bit, set below
	logic [DIDX_W:0]   flush_cnt;
	logic [DIDX_W-1:0] flush_idx;
	logic              flush_way;
	logic              flush_last;

	function automatic word_t blk_addr(
		input logic [DTAG_W-1:0] t,
		input logic [DIDX_W-1:0] i,
		input logic [DBLK_W-1:0] b
	);
		dcachef_t a;
		a.tag    = t;
		a.idx    = i;
		a.blkoff = b;
		a.bytoff = '0;
		return word_t'(a);
	endfunction

	assign req_addr = dcachef_t'(dmemaddr);
	assign req_tag  = req_addr.tag;
	assign req_idx  = req_addr.idx;
	assign req_off  = req_addr.blkoff;

	assign req      = dmemREN || dmemWEN;
	assign mem_done = !dwait;

	// tag compare on both ways
	assign hit0    = valid_q[0][req_idx] && (tag_q[0][req_idx] == req_tag);
	assign hit1    = valid_q[1][req_idx] && (tag_q[1][req_idx] == req_tag);
	assign hit     = hit0 || hit1;
	assign hit_way = hit1;

	assign idle_hit = (state == IDLE) && !halt && req && hit;

	// empty way first, else the one not used last
	always_comb begin
		if (!valid_q[0][req_idx]) begin
			victim_sel = 1'b0;
		end else if (!valid_q[1][req_idx]) begin
			victim_sel = 1'b1;
		end else begin
			victim_sel = !mru_q[req_idx];
		end
	end

	assign victim_dirty = valid_q[victim_sel][req_idx] && dirty_q[victim_sel][req_idx];

	assign flush_idx  = flush_cnt[DIDX_W-1:0];
	assign flush_way  = flush_cnt[DIDX_W];
	assign flush_last = &flush_cnt;

	// datapath outputs
	assign rd_way   = (state == FILL) ? victim_q : hit_way;
	assign dmemload = data_q[rd_way][req_idx][req_off];
	assign dhit     = idle_hit || (state == FILL);
	assign flushed  = (state == FLUSHED);

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (halt) begin
					next_state = FLUSH0;
				end else if (req && !hit) begin
					next_state = victim_dirty ? WB0 : FETCH0;
				end
			end
			WB0: begin
				if (mem_done) begin
					next_state = WB1;
				end
			end
			WB1: begin
				if (mem_done) begin
					next_state = FETCH0;
				end
			end
			FETCH0: begin
				if (mem_done) begin
					next_state = FETCH1;
				end
			end
			FETCH1: begin
				if (mem_done) begin
					next_state = FILL;
				end
			end
			FILL: begin
				next_state = IDLE;
			end
			FLUSH0: begin
				// clean blocks are skipped in one cycle
				if (!dirty_q[flush_way][flush_idx]) begin
					if (flush_last) begin
						next_state = FLUSHED;
					end
				end else if (mem_done) begin
					next_state = FLUSH1;
				end
			end
			FLUSH1: begin
				if (mem_done) begin
					next_state = flush_last ? FLUSHED : FLUSH0;
				end
			end
			default: begin
				next_state = state;
			end
		endcase
	end

	// memory bus drive
	always_comb begin
		dREN   = 1'b0;
		dWEN   = 1'b0;
		daddr  = blk_addr(req_tag, req_idx, DBLK_W'(0));
		dstore = data_q[victim_q][req_idx][0];
		case (state)
			WB0: begin
				dWEN   = 1'b1;
				daddr  = blk_addr(tag_q[victim_q][req_idx], req_idx, DBLK_W'(0));
				dstore = data_q[victim_q][req_idx][0];
			end
			WB1: begin
				dWEN   = 1'b1;
				daddr  = blk_addr(tag_q[victim_q][req_idx], req_idx, DBLK_W'(1));
				dstore = data_q[victim_q][req_idx][1];
			end
			FETCH0: begin
				dREN  = 1'b1;
				daddr = blk_addr(req_tag, req_idx, DBLK_W'(0));
			end
			FETCH1: begin
				dREN  = 1'b1;
				daddr = blk_addr(req_tag, req_idx, DBLK_W'(1));
			end
			FLUSH0: begin
				dWEN   = dirty_q[flush_way][flush_idx];
				daddr  = blk_addr(tag_q[flush_way][flush_idx], flush_idx, DBLK_W'(0));
				dstore = data_q[flush_way][flush_idx][0];
			end
			FLUSH1: begin
				dWEN   = 1'b1;
				daddr  = blk_addr(tag_q[flush_way][flush_idx], flush_idx, DBLK_W'(1));
				dstore = data_q[flush_way][flush_idx][1];
			end
			default: begin
				dREN = 1'b0;
			end
		endcase
	end

	// control state: fsm, valid, dirty, lru, victim, flush walk
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state     <= IDLE;
			victim_q  <= 1'b0;
			flush_cnt <= '0;
			mru_q     <= '0;
			for (int w = 0; w < DWAYS; w++) begin
				for (int s = 0; s < DSETS; s++) begin
					valid_q[w][s] <= 1'b0;
					dirty_q[w][s] <= 1'b0;
				end
			end
		end else begin
			state <= next_state;
			case (state)
				IDLE: begin
					if (idle_hit) begin
						mru_q[req_idx] <= hit_way;
						if (dmemWEN) begin
							dirty_q[hit_way][req_idx] <= 1'b1;
						end
					end else if (!halt && req) begin
						// victim stays fixed for the whole miss
						victim_q <= victim_sel;
					end
				end
				FILL: begin
					valid_q[victim_q][req_idx] <= 1'b1;
					dirty_q[victim_q][req_idx] <= dmemWEN;
					mru_q[req_idx]             <= victim_q;
				end
				FLUSH0: begin
					if (!dirty_q[flush_way][flush_idx]) begin
						flush_cnt <= flush_cnt + 1'b1;
					end
				end
				FLUSH1: begin
					if (mem_done) begin
						dirty_q[flush_way][flush_idx] <= 1'b0;
						flush_cnt                     <= flush_cnt + 1'b1;
					end
				end
				default: begin
					victim_q <= victim_q;
				end
			endcase
		end
	end

	// tags and data
	always_ff @(posedge CLK) begin
		case (state)
			IDLE: begin
				if (idle_hit && dmemWEN) begin
					data_q[hit_way][req_idx][req_off] <= dmemstore;
				end
			end
			FETCH0: begin
				if (mem_done) begin
					data_q[victim_q][req_idx][0] <= dload;
				end
			end
			FETCH1: begin
				if (mem_done) begin
					data_q[victim_q][req_idx][1] <= dload;
				end
			end
			FILL: begin
				tag_q[victim_q][req_idx] <= req_tag;
				// write miss merges into the fetched block
				if (dmemWEN) begin
					data_q[victim_q][req_idx][req_off] <= dmemstore;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

//--- cpu_types_pkg.sv
package cpu_types_pkg;

	// data word
	localparam int WORD_W = 32;
	typedef logic [WORD_W-1:0] word_t;

	// address field widths, msb first: tag, index, block offset, byte offset
	localparam int DTAG_W = 26;
	localparam int DIDX_W = 3;
	localparam int DBLK_W = 1;
	localparam int DBYT_W = 2;

	// cache geometry
	localparam int DWAYS  = 2;
	localparam int DSETS  = 1 << DIDX_W;
	localparam int DWORDS = 1 << DBLK_W;

	// data cache view of an address
	typedef struct packed {
		logic [DTAG_W-1:0] tag;
		logic [DIDX_W-1:0] idx;
		logic [DBLK_W-1:0] blkoff;
		logic [DBYT_W-1:0] bytoff;
	} dcachef_t;

	// pattern mixed into every word address at reset
	localparam word_t INIT_KEY = 32'h5a3c_0f00;

	// memory contents after reset, by word address
	function automatic word_t init_word(input word_t waddr);
		word_t val;
		val = waddr ^ INIT_KEY;
		return val;
	endfunction

endpackage
